// ==== i2c_eeprom.f ====
src/i2c_eeprom_pkg.sv
src/i2c_line_sync.sv
src/i2c_slave_fsm.sv
src/eeprom_mem_ctrl.sv
src/i2c_eeprom_top.sv
test/i2c_bus_master.sv
test/tb_i2c_eeprom.sv

// ==== test/tb_i2c_eeprom.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_eeprom;
    import i2c_eeprom_pkg::*;

    localparam dev_sel_t BOARD_SEL = 3'b101;
    localparam int       NUM_MIX   = 40;

    logic        clk;
    logic        rst_n;
    dev_sel_t    dev_sel;
    logic        scl;
    logic        sda_drv;
    logic        sda_out;
    logic        sda_line;
    logic [31:0] lfsr;
    int          err_count;
    logic        expect_release;    // DUT must leave SDA alone
    byte_t       model_mem [MEM_DEPTH];
    logic        model_set [MEM_DEPTH];
    mem_addr_t   model_ptr;
    mem_addr_t   last_wr_addr;

    assign sda_line = sda_drv & sda_out;   // Open-drain wired AND

    i2c_eeprom_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .scl_raw (scl),
        .sda_raw (sda_line),
        .dev_sel (dev_sel),
        .sda_out (sda_out)
    );

    i2c_bus_master bus (
        .clk      (clk),
        .sda_line (sda_line),
        .scl      (scl),
        .sda_drv  (sda_drv)
    );

    always #5 clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected)
        else
        begin
            $display("ERR %0t %s expected %02h actual %02h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    always @(negedge clk)
    begin
        if (expect_release)
        begin
            assert (sda_out === 1'b1)
            else
            begin
                $display("ERR %0t sda_out expected 1 actual %b", $time, sda_out);
                err_count++;
            end
        end
    end

    task automatic send_checked(input byte_t data, input logic exp_ack, input string name);
        logic ack;
        bus.write_byte(data, ack);
        check_value(name, {7'd0, exp_ack}, {7'd0, ack});
    endtask

    task automatic address_phase(input mem_addr_t addr);
        send_checked({DEVICE_TYPE, BOARD_SEL, 1'b0}, 1'b0, "ack write id");
        send_checked({5'(rand_bits(5)), addr[10:8]}, 1'b0, "ack addr hi");   // Junk upper bits
        send_checked(addr[7:0], 1'b0, "ack addr lo");
        model_ptr = addr;
    endtask

    task automatic read_burst(input int len);
        byte_t b;
        for (int i = 0; i < len; i++)
        begin
            bus.read_byte(i == len - 1, b);   // NACK ends the burst
            if (model_set[model_ptr])
                check_value($sformatf("sda read byte at %0d", model_ptr),
                            model_mem[model_ptr], b);
            model_ptr = mem_addr_t'((model_ptr + 1) % MEM_DEPTH);
        end
        bus.stop_cond();
    endtask

    task automatic write_burst(input mem_addr_t addr, input int len);
        byte_t data;
        bus.start_cond();
        address_phase(addr);
        for (int i = 0; i < len; i++)
        begin
            data = byte_t'(rand_bits(8));
            send_checked(data, 1'b0, "ack write data");
            model_mem[model_ptr] = data;
            model_set[model_ptr] = 1'b1;
            model_ptr = mem_addr_t'((model_ptr + 1) % MEM_DEPTH);
        end
        bus.stop_cond();
        last_wr_addr = addr;
    endtask

    task automatic random_read(input mem_addr_t addr, input int len);
        bus.start_cond();
        address_phase(addr);
        bus.start_cond();
        send_checked({DEVICE_TYPE, BOARD_SEL, 1'b1}, 1'b0, "ack read id");
        read_burst(len);
    endtask

    task automatic current_read(input int len);
        bus.start_cond();
        send_checked({DEVICE_TYPE, BOARD_SEL, 1'b1}, 1'b0, "ack read id");
        read_burst(len);
    endtask

    task automatic foreign_id(input logic wrong_type);
        logic [3:0] type_code;
        dev_sel_t   sel;
        type_code = DEVICE_TYPE;
        sel       = BOARD_SEL;
        if (wrong_type)
            type_code = 4'(rand_bits(4));
        else
            sel = 3'(rand_bits(3));
        if (type_code == DEVICE_TYPE && sel == BOARD_SEL)
            sel = sel ^ 3'b010;
        bus.start_cond();
        expect_release = 1'b1;
        send_checked({type_code, sel, 1'(rand_bits(1))}, 1'b1, "ack foreign id");
        expect_release = 1'b0;
        bus.stop_cond();
    endtask

    initial
    begin
        mem_addr_t addr;
        int        op;
        int        len;
        clk            = 1'b0;
        rst_n          = 1'b0;
        dev_sel        = BOARD_SEL;
        lfsr           = 32'd73661;
        err_count      = 0;
        expect_release = 1'b0;
        model_ptr      = '0;
        last_wr_addr   = '0;
        for (int i = 0; i < MEM_DEPTH; i++)
            model_set[i] = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        bus.step(4);

        // Idle bus, then a bare START and STOP
        check_value("sda_out", 8'h01, {7'd0, sda_out});
        expect_release = 1'b1;
        bus.start_cond();
        bus.stop_cond();
        expect_release = 1'b0;

        addr = mem_addr_t'(rand_bits(11));
        write_burst(addr, 1);
        random_read(addr, 1);

        // Bursts across the top of the array
        write_burst(11'd2045, 6);
        random_read(11'd2045, 6);
        random_read(11'd2045, 2);
        current_read(4);
        addr = mem_addr_t'(rand_bits(11));
        len  = 1 + int'(rand_bits(3)) % 6;
        write_burst(addr, len);
        random_read(addr, len);

        addr = mem_addr_t'(rand_bits(11));
        write_burst(addr, 4);
        random_read(addr, 1);
        foreign_id(1'b0);
        foreign_id(1'b1);
        current_read(3);   // Pointer must be where the last read left it

        for (int n = 0; n < NUM_MIX; n++)
        begin
            op   = int'(rand_bits(2));
            len  = 1 + int'(rand_bits(3)) % 6;
            addr = rand_bits(1) ? last_wr_addr : mem_addr_t'(rand_bits(11));
            case (op)
                0:       write_burst(addr, len);
                1:       random_read(addr, len);
                2:       current_read(len);
                default: foreign_id(1'(rand_bits(1)));
            endcase
        end

        $display("Errors: %0d check failures, %0d bus timeouts", err_count, bus.timeout_count);
        if (err_count == 0 && bus.timeout_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/i2c_bus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_bus_master (
    input  logic clk,
    input  logic sda_line,
    output logic scl,
    output logic sda_drv
);
    import i2c_eeprom_pkg::*;

    localparam int HALF      = 20;    // clk cycles per SCL phase
    localparam int SETUP     = 5;     // SDA moves this long after SCL falls
    localparam int IDLE_WAIT = 200;

    int timeout_count = 0;

    initial
    begin
        scl     = 1'b1;
        sda_drv = 1'b1;
    end

    // Ends 1 ns after a rising clk edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_bit(input logic b);
        sda_drv = b;
        step(HALF);
        scl = 1'b1;
        step(HALF);
        scl = 1'b0;
        step(SETUP);
    endtask

    task automatic read_bit(output logic b);
        sda_drv = 1'b1;
        step(HALF);
        scl = 1'b1;
        step(HALF / 2);
        b = sda_line;                 // Middle of the high phase
        step(HALF - HALF / 2);
        scl = 1'b0;
        step(SETUP);
    endtask

    task automatic start_cond();
        int waited;
        if (!scl)
        begin
            sda_drv = 1'b1;           // Repeated start
            step(HALF);
            scl = 1'b1;
            step(HALF);
        end
        waited = 0;
        while (sda_line !== 1'b1 && waited < IDLE_WAIT)
        begin
            step(1);
            waited++;
        end
        if (sda_line !== 1'b1)
        begin
            $display("Bus master: SDA still held low at %0t, no START possible", $time);
            timeout_count++;
        end
        sda_drv = 1'b0;
        step(HALF);
        scl = 1'b0;
        step(SETUP);
    endtask

    task automatic stop_cond();
        sda_drv = 1'b0;
        step(HALF);
        scl = 1'b1;
        step(HALF);
        sda_drv = 1'b1;
        step(HALF);
    endtask

    task automatic write_byte(input byte_t data, output logic ack);
        for (int i = 7; i >= 0; i--)
            write_bit(data[i]);
        read_bit(ack);                // 0 is ACK
    endtask

    task automatic read_byte(input logic nack, output byte_t data);
        logic b;
        data = '0;
        for (int i = 7; i >= 0; i--)
        begin
            read_bit(b);
            data[i] = b;
        end
        write_bit(nack);
    endtask

endmodule

`default_nettype wire

// ==== src/i2c_eeprom_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_eeprom_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     scl_raw,
    input  logic                     sda_raw,
    input  i2c_eeprom_pkg::dev_sel_t dev_sel,
    output logic                     sda_out
);
    import i2c_eeprom_pkg::*;

    i2c_bus_evt_t evt;
    mem_req_t     req;
    byte_t        rdata;
    logic         rdata_valid;

    // Raw pins to synchronized levels and bus events
    i2c_line_sync u_line_sync (
        .clk     (clk),
        .rst_n   (rst_n),
        .scl_raw (scl_raw),
        .sda_raw (sda_raw),
        .evt     (evt)
    );

    i2c_slave_fsm u_slave_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .dev_sel     (dev_sel),
        .evt         (evt),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .req         (req),
        .sda_out     (sda_out)       // Open drain, low drives the line
    );

    eeprom_mem_ctrl u_mem_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

`default_nettype wire

// ==== src/eeprom_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_mem_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  i2c_eeprom_pkg::mem_req_t req,
    output i2c_eeprom_pkg::byte_t    rdata,
    output logic                     rdata_valid
);
    import i2c_eeprom_pkg::*;

    byte_t     mem [MEM_DEPTH];
    mem_addr_t ptr;
    mem_addr_t ptr_inc;

    // 11-bit pointer wraps from 2047 to 0 on its own
    assign ptr_inc = ptr + mem_addr_t'(1);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ptr         <= '0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            rdata_valid <= req.rd_en;

            if (req.addr_load)
                ptr <= req.addr;
            else if (req.wr_en || req.rd_en)
                ptr <= ptr_inc;   // Advance after every byte
        end
    end

    always_ff @(posedge clk)
    begin
        if (req.wr_en)
            mem[ptr] <= req.wdata;

        if (req.rd_en)
            rdata <= mem[ptr];
    end

endmodule

`default_nettype wire

// ==== src/i2c_slave_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_fsm (
    input  logic                         clk,
    input  logic                         rst_n,
    input  i2c_eeprom_pkg::dev_sel_t     dev_sel,
    input  i2c_eeprom_pkg::i2c_bus_evt_t evt,
    input  i2c_eeprom_pkg::byte_t        rdata,
    input  logic                         rdata_valid,
    output i2c_eeprom_pkg::mem_req_t     req,
    output logic                         sda_out
);
    import i2c_eeprom_pkg::*;

    slave_state_e state;
    logic [2:0]   bit_cnt;
    logic         rd_mode;      // R/W bit of the last device ID, 1 is read
    logic [6:0]   rx_shift;
    logic [2:0]   addr_hi;      // Upper five bits of the high byte are ignored
    byte_t        rx_byte;
    byte_t        rd_shift;
    logic         byte_done;
    logic         id_match;
    logic         in_byte;
    logic         ack_drive;

    // Byte as seen at the 8th rising edge
    assign rx_byte   = {rx_shift, evt.sda};
    assign byte_done = evt.scl_rise && (bit_cnt == 3'd7);
    assign id_match  = (rx_shift == {DEVICE_TYPE, dev_sel});

    assign in_byte   = (state == DEV_ID)  || (state == ADDR_HI) ||
                       (state == ADDR_LO) || (state == WR_DATA) ||
                       (state == RD_DATA);

    assign ack_drive = (state == ACK_ID)      || (state == ACK_ADDR_HI) ||
                       (state == ACK_ADDR_LO) || (state == ACK_WR_DATA);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= IDLE;
            bit_cnt <= 3'd0;
            rd_mode <= 1'b0;
            req     <= '0;
        end
        else
        begin
            req.addr_load <= 1'b0;
            req.wr_en     <= 1'b0;
            req.rd_en     <= 1'b0;

            if (evt.bus_start)
            begin
                state   <= DEV_ID;   // Also taken on a repeated start
                bit_cnt <= 3'd0;
            end
            else if (evt.bus_stop)
            begin
                state <= IDLE;
            end
            else if (evt.scl_rise)
            begin
                if (in_byte)
                    bit_cnt <= bit_cnt + 3'd1;   // Wraps to 0 after the 8th bit

                case (state)
                    DEV_ID:
                        if (byte_done)
                        begin
                            rd_mode <= rx_byte[0];
                            if (id_match)
                            begin
                                state     <= ACK_ID;
                                req.rd_en <= rx_byte[0];   // Prefetch first read byte
                            end
                            else
                            begin
                                state <= IDLE;
                            end
                        end

                    ACK_ID:
                        state <= rd_mode ? RD_DATA : ADDR_HI;

                    ADDR_HI:
                        if (byte_done)
                            state <= ACK_ADDR_HI;

                    ACK_ADDR_HI:
                        state <= ADDR_LO;

                    ADDR_LO:
                        if (byte_done)
                        begin
                            state         <= ACK_ADDR_LO;
                            req.addr_load <= 1'b1;
                            req.addr      <= {addr_hi, rx_byte};
                        end

                    ACK_ADDR_LO:
                        state <= WR_DATA;

                    WR_DATA:
                        if (byte_done)
                        begin
                            state     <= ACK_WR_DATA;
                            req.wr_en <= 1'b1;
                            req.wdata <= rx_byte;
                        end

                    ACK_WR_DATA:
                        state <= WR_DATA;

                    RD_DATA:
                        if (byte_done)
                            state <= MASTER_ACK;

                    MASTER_ACK:
                        // Master ACK asks for the next byte
                        if (!evt.sda)
                        begin
                            state     <= RD_DATA;
                            req.rd_en <= 1'b1;
                        end
                        else
                        begin
                            state <= IDLE;
                        end

                    default:
                        state <= IDLE;
                endcase
            end
        end
    end

    // SDA only changes while SCL is low
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sda_out <= 1'b1;
        end
        else if (evt.bus_start || evt.bus_stop)
        begin
            sda_out <= 1'b1;
        end
        else if (evt.scl_fall)
        begin
            if (ack_drive)
                sda_out <= 1'b0;
            else if (state == RD_DATA)
                sda_out <= rd_shift[7];   // MSB first
            else
                sda_out <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (evt.scl_rise)
            rx_shift <= rx_byte[6:0];

        if (byte_done && (state == ADDR_HI))
            addr_hi <= rx_byte[2:0];

        if (rdata_valid)
            rd_shift <= rdata;
        else if (evt.scl_fall && (state == RD_DATA))
            rd_shift <= {rd_shift[6:0], 1'b1};
    end

endmodule

`default_nettype wire

// ==== src/i2c_line_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_line_sync (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         scl_raw,
    input  logic                         sda_raw,
    output i2c_eeprom_pkg::i2c_bus_evt_t evt
);
    import i2c_eeprom_pkg::*;

    logic [SYNC_STAGES-1:0] scl_sync;
    logic [SYNC_STAGES:0]   sda_sync;   // One stage deeper, SDA lags SCL
    logic                   scl_s;
    logic                   sda_s;

    assign scl_s = scl_sync[SYNC_STAGES-1];
    assign sda_s = sda_sync[SYNC_STAGES];

    // Idle bus is high on both lines
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scl_sync <= '1;
            sda_sync <= '1;
        end
        else
        begin
            scl_sync <= {scl_sync[SYNC_STAGES-2:0], scl_raw};
            sda_sync <= {sda_sync[SYNC_STAGES-1:0], sda_raw};
        end
    end

    // evt.scl and evt.sda hold the previous synchronized levels
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            evt.scl       <= 1'b1;
            evt.sda       <= 1'b1;
            evt.scl_rise  <= 1'b0;
            evt.scl_fall  <= 1'b0;
            evt.bus_start <= 1'b0;
            evt.bus_stop  <= 1'b0;
        end
        else
        begin
            evt.scl       <= scl_s;
            evt.sda       <= sda_s;
            evt.scl_rise  <= scl_s & ~evt.scl;
            evt.scl_fall  <= ~scl_s & evt.scl;
            evt.bus_start <= evt.sda & ~sda_s & scl_s;   // SDA falls, SCL high
            evt.bus_stop  <= ~evt.sda & sda_s & scl_s;   // SDA rises, SCL high
        end
    end

endmodule

`default_nettype wire

// ==== src/i2c_eeprom_pkg.sv ====
`default_nettype none

package i2c_eeprom_pkg;

    localparam int          BYTE_W      = 8;
    localparam int          ADDR_W      = 11;
    localparam int          MEM_DEPTH   = 2048;
    localparam int          SYNC_STAGES = 2;
    localparam logic [3:0]  DEVICE_TYPE = 4'b1010;   // 24Cxx type code

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [2:0]        dev_sel_t;

    typedef enum logic [3:0] {
        IDLE,
        DEV_ID,
        ACK_ID,
        ADDR_HI,
        ACK_ADDR_HI,
        ADDR_LO,
        ACK_ADDR_LO,
        WR_DATA,
        ACK_WR_DATA,
        RD_DATA,
        MASTER_ACK
    } slave_state_e;

    // Synchronized bus levels and the events derived from them
    typedef struct packed {
        logic scl;
        logic sda;
        logic scl_rise;
        logic scl_fall;
        logic bus_start;
        logic bus_stop;
    } i2c_bus_evt_t;

    typedef struct packed {
        logic      addr_load;
        logic      wr_en;
        logic      rd_en;
        mem_addr_t addr;
        byte_t     wdata;
    } mem_req_t;

endpackage

`default_nettype wire
